// ==== compile.f ====
+incdir+src
src/prof_pkg.sv
src/prof_event_decode.sv
src/prof_counter_bank.sv
src/prof_axil_regs.sv
src/cu_profiler_top.sv
verification/cu_profiler_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Builds the profiler testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/100ps -Wno-fatal \
	-f compile.f --top-module cu_profiler_tb \
	-Mdir obj_dir -o cu_profiler_sim

./obj_dir/cu_profiler_sim | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "run_sim: testbench reported failure"
	exit 1
fi

echo "run_sim: no failure found in sim.log"
exit 0

// ==== verification/cu_profiler_tb.sv ====
`include "prof_macros.svh"

module cu_profiler_tb import prof_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_CYCLES = 400;
	// several times the roughly 750 cycles that all tests spend including register traffic
	localparam int TIMEOUT_CYCLES = 5000;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef struct packed {
		logic salu_done;
		logic salu_branch_en;
		logic salu_select;
		vec_mask_t vec_done;
		vec_mask_t vec_select;
		vec_mask_t vec_fu_select;
		logic lsu_select;
		logic lsu_sgpr_done;
		logic lsu_vgpr_done;
	} strobes_t;

	logic clk;
	logic rst_n;
	strobes_t strb;
	reg_addr_t awaddr;
	logic awvalid;
	logic awready;
	logic [`PROF_DATA_W-1:0] wdata;
	logic [`PROF_STRB_W-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	reg_addr_t araddr;
	logic arvalid;
	logic arready;
	logic [`PROF_DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	prof_counts_t model;
	vec_mask_t model_flags;
	logic model_enable;
	int errors;
	int checks;
	int test_start;
	int cycles;

	cu_profiler_top dut_i (
		.clk, .rst_n,
		.salu_done(strb.salu_done), .salu_branch_en(strb.salu_branch_en),
		.salu_select(strb.salu_select), .vec_done(strb.vec_done),
		.vec_select(strb.vec_select), .vec_fu_select(strb.vec_fu_select),
		.lsu_select(strb.lsu_select), .lsu_sgpr_done(strb.lsu_sgpr_done),
		.lsu_vgpr_done(strb.lsu_vgpr_done),
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready, .bresp, .bvalid,
		.bready, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, a bus handshake or test never finished", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	// adds one cycle of strobes to the counts using the flags from before that cycle
	function automatic prof_counts_t next_counts(input prof_counts_t cur, input strobes_t s,
			input vec_mask_t flags);
		prof_counts_t n;
		n = cur;
		for (int i = 0; i < `PROF_NUM_VEC_UNITS; i++) begin
			if (s.vec_select[i]) begin
				n.valu_start = n.valu_start + 32'd1;
			end
			if (s.vec_done[i] && flags[i]) begin
				n.valu_finish = n.valu_finish + 32'd1;
			end
		end
		if (s.salu_select) begin
			n.salu_start = n.salu_start + 32'd1;
		end
		if (s.salu_done || s.salu_branch_en) begin
			n.salu_finish = n.salu_finish + 32'd1;
		end
		if (s.lsu_select) begin
			n.mem_start = n.mem_start + 32'd1;
		end
		if (s.lsu_sgpr_done || s.lsu_vgpr_done) begin
			n.mem_finish = n.mem_finish + 32'd1;
		end
		return n;
	endfunction

	// a credited done with select low disarms the unit and an uncredited done with select high arms it
	function automatic vec_mask_t next_flags(input vec_mask_t flags, input strobes_t s);
		vec_mask_t n;
		n = flags;
		for (int i = 0; i < `PROF_NUM_VEC_UNITS; i++) begin
			if (s.vec_done[i] && flags[i] && !s.vec_fu_select[i]) begin
				n[i] = 1'b0;
			end else if (s.vec_done[i] && !flags[i] && s.vec_fu_select[i]) begin
				n[i] = 1'b1;
			end
		end
		return n;
	endfunction

	function automatic string field_name(input int i);
		case (i)
			0: return "salu_start";
			1: return "salu_finish";
			2: return "valu_start";
			3: return "valu_finish";
			4: return "mem_start";
			default: return "mem_finish";
		endcase
	endfunction

	task automatic check_value(input string name, input prof_count_t expected,
			input prof_count_t actual);
		checks++;
		assert (actual == expected) else begin
			$display("CHECK FAILED at %0t: %s expected 0x%08h, got 0x%08h",
				$time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic report_problem(input string what);
		$display("error at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic next_cycle(input int n);
		repeat (n) begin
			@(posedge clk);
			#10;
		end
	endtask

	task automatic write_reg(input reg_addr_t addr, input prof_count_t data,
			output logic [1:0] resp);
		awaddr = addr;
		wdata = data;
		wstrb = '1;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b1;
		while (!(awready && wready)) begin
			next_cycle(1);
		end
		next_cycle(1);
		awvalid = 1'b0;
		wvalid = 1'b0;
		assert (bvalid) else report_problem("bvalid did not rise after the write handshake");
		resp = bresp;
		next_cycle(1);
		assert (!bvalid) else report_problem("bvalid stayed high after the response was taken");
	endtask

	task automatic read_reg(input reg_addr_t addr, output prof_count_t data,
			output logic [1:0] resp);
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b1;
		while (!arready) begin
			next_cycle(1);
		end
		next_cycle(1);
		arvalid = 1'b0;
		data = rdata;
		resp = rresp;
		next_cycle(1);
	endtask

	task automatic check_reg(input string name, input reg_addr_t addr,
			input prof_count_t expected);
		prof_count_t data;
		logic [1:0] resp;
		read_reg(addr, data, resp);
		check_value(name, expected, data);
		check_value({name, " rresp"}, prof_count_t'(RESP_OKAY), prof_count_t'(resp));
	endtask

	task automatic check_counts(input string prefix, input reg_addr_t base,
			input prof_counts_t expected);
		for (int i = 0; i < 6; i++) begin
			check_reg({prefix, " ", field_name(i)}, reg_addr_t'(base + 8'(4 * i)),
				expected[`PROF_DATA_W * (5 - i) +: `PROF_DATA_W]);
		end
	endtask

	// the model flags follow every strobe but the counts only move while enabled
	task automatic apply_strobes(input int n);
		logic [31:0] r;
		strobes_t s;
		for (int c = 0; c < n; c++) begin
			r = $urandom;
			s = r[$bits(strobes_t)-1:0];
			strb = s;
			if (model_enable) begin
				model = next_counts(model, s, model_flags);
			end
			model_flags = next_flags(model_flags, s);
			next_cycle(1);
		end
		strb = '0;
	endtask

	task automatic finish_test(input string name);
		$display("%s: %0d errors", name, errors - test_start);
		test_start = errors;
	endtask

	initial begin
		prof_count_t data;
		prof_count_t held;
		prof_count_t seq_start;
		logic [1:0] resp;
		clk = 1'b0;
		rst_n = 1'b0;
		strb = '0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		model = '0;
		model_flags = '1;
		model_enable = 1'b1;
		errors = 0;
		checks = 0;
		test_start = 0;
		cycles = 0;
		void'($urandom(32'h8084));
		repeat (RESET_CYCLES) @(posedge clk);
		#10;
		rst_n = 1'b1;
		next_cycle(1);

		check_reg("ctrl", `PROF_REG_CTRL, 32'd1);
		check_reg("period", `PROF_REG_PERIOD, 32'd100);
		check_counts("live", `PROF_REG_LIVE_BASE, model);
		finish_test("reset values");

		apply_strobes(RANDOM_CYCLES);
		next_cycle(2);
		check_counts("live", `PROF_REG_LIVE_BASE, model);
		finish_test("random strobes");

		write_reg(`PROF_REG_CTRL, 32'd0, resp);
		check_value("bresp ctrl", prof_count_t'(RESP_OKAY), prof_count_t'(resp));
		model_enable = 1'b0;
		apply_strobes(60);
		next_cycle(2);
		check_counts("live", `PROF_REG_LIVE_BASE, model);
		write_reg(`PROF_REG_CTRL, 32'd3, resp);
		check_value("bresp ctrl", prof_count_t'(RESP_OKAY), prof_count_t'(resp));
		model_enable = 1'b1;
		model = '0;
		check_counts("live", `PROF_REG_LIVE_BASE, model);
		check_counts("snap", `PROF_REG_SNAP_BASE, model);
		check_reg("seq", `PROF_REG_SEQ, 32'd0);
		finish_test("enable and clear");

		write_reg(`PROF_REG_PERIOD, 32'd20, resp);
		check_value("bresp period", prof_count_t'(RESP_OKAY), prof_count_t'(resp));
		check_reg("period", `PROF_REG_PERIOD, 32'd20);
		apply_strobes(60);
		read_reg(`PROF_REG_SEQ, seq_start, resp);
		next_cycle(45);
		check_counts("snap", `PROF_REG_SNAP_BASE, model);
		check_counts("live", `PROF_REG_LIVE_BASE, model);
		read_reg(`PROF_REG_SEQ, data, resp);
		assert (data > seq_start) else begin
			report_problem("sample sequence did not advance while idle");
		end
		finish_test("sample period");

		read_reg(8'h0c, data, resp);
		check_value("rdata unmapped", 32'd0, data);
		check_value("rresp unmapped", prof_count_t'(RESP_SLVERR), prof_count_t'(resp));
		write_reg(`PROF_REG_LIVE_BASE, 32'h1234_5678, resp);
		check_value("bresp live", prof_count_t'(RESP_SLVERR), prof_count_t'(resp));
		check_counts("live", `PROF_REG_LIVE_BASE, model);
		check_reg("period", `PROF_REG_PERIOD, 32'd20);
		check_reg("ctrl", `PROF_REG_CTRL, 32'd1);
		// hold the read response for a few cycles before taking it
		araddr = `PROF_REG_PERIOD;
		arvalid = 1'b1;
		rready = 1'b0;
		while (!arready) begin
			next_cycle(1);
		end
		next_cycle(1);
		arvalid = 1'b0;
		held = rdata;
		for (int k = 0; k < 5; k++) begin
			assert (rvalid) else report_problem("rvalid dropped while rready was low");
			assert (!arready) else report_problem("arready was high with a read response pending");
			check_value("rdata held", held, rdata);
			next_cycle(1);
		end
		check_value("rdata period", 32'd20, held);
		rready = 1'b1;
		next_cycle(1);
		assert (!rvalid) else report_problem("rvalid stayed high after the read was accepted");
		finish_test("bus errors and stall");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== src/cu_profiler_top.sv ====
`include "prof_macros.svh"

module cu_profiler_top import prof_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    salu_done,
	input  logic                    salu_branch_en,
	input  logic                    salu_select,
	input  vec_mask_t               vec_done,
	input  vec_mask_t               vec_select,
	input  vec_mask_t               vec_fu_select,
	input  logic                    lsu_select,
	input  logic                    lsu_sgpr_done,
	input  logic                    lsu_vgpr_done,
	input  reg_addr_t               awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [`PROF_DATA_W-1:0] wdata,
	input  logic [`PROF_STRB_W-1:0] wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  reg_addr_t               araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [`PROF_DATA_W-1:0] rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready
);

	prof_events_t events;
	prof_ctrl_t ctrl;
	prof_counts_t live;
	prof_counts_t snap;
	prof_count_t sample_seq;

	prof_event_decode decode_i (
		.clk, .rst_n, .salu_done, .salu_branch_en, .salu_select, .vec_done, .vec_select,
		.vec_fu_select, .lsu_select, .lsu_sgpr_done, .lsu_vgpr_done, .events
	);

	prof_counter_bank bank_i (
		.clk, .rst_n, .events, .ctrl, .live, .snap, .sample_seq
	);

	prof_axil_regs regs_i (
		.clk, .rst_n, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid,
		.rready, .ctrl, .live, .snap, .sample_seq
	);

endmodule

// ==== src/prof_axil_regs.sv ====
`include "prof_macros.svh"

module prof_axil_regs import prof_pkg::*; (
	input  logic                    clk,
	input  logic                    rst_n,
	input  reg_addr_t               awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [`PROF_DATA_W-1:0] wdata,
	input  logic [`PROF_STRB_W-1:0] wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  reg_addr_t               araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [`PROF_DATA_W-1:0] rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready,
	output prof_ctrl_t              ctrl,
	input  prof_counts_t            live,
	input  prof_counts_t            snap,
	input  prof_count_t             sample_seq
);

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic wr_hs;
	logic rd_hs;
	logic wr_ctrl;
	logic wr_period;
	logic enable_q;
	logic clear_q;
	prof_count_t period_q;
	logic [`PROF_DATA_W-1:0] rd_word;
	logic rd_ok;

	// address and data are taken together, one response outstanding
	assign wr_hs = awvalid && wvalid && !bvalid;
	assign awready = wr_hs;
	assign wready = wr_hs;

	assign arready = !rvalid;
	assign rd_hs = arvalid && !rvalid;

	assign wr_ctrl = (awaddr == `PROF_REG_CTRL);
	assign wr_period = (awaddr == `PROF_REG_PERIOD);

	assign ctrl.enable = enable_q;
	assign ctrl.clear = clear_q;
	assign ctrl.period = period_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable_q <= 1'b1;
			clear_q <= 1'b0;
			period_q <= `PROF_DEFAULT_PERIOD;
			bvalid <= 1'b0;
		end else begin
			clear_q <= 1'b0;
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			if (wr_hs) begin
				bvalid <= 1'b1;
				if (wr_ctrl && wstrb[0]) begin
					enable_q <= wdata[0];
					clear_q <= wdata[1];
				end
				if (wr_period) begin
					for (int b = 0; b < `PROF_STRB_W; b++) begin
						if (wstrb[b]) begin
							period_q[8*b +: 8] <= wdata[8*b +: 8];
						end
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_hs) begin
			bresp <= (wr_ctrl || wr_period) ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// clear is a pulse and always reads back as zero
	always_comb begin
		rd_ok = 1'b1;
		case (araddr)
			`PROF_REG_CTRL: rd_word = {{(`PROF_DATA_W-1){1'b0}}, enable_q};
			`PROF_REG_PERIOD: rd_word = period_q;
			`PROF_REG_SEQ: rd_word = sample_seq;
			`PROF_REG_LIVE_BASE + 8'h00: rd_word = live.salu_start;
			`PROF_REG_LIVE_BASE + 8'h04: rd_word = live.salu_finish;
			`PROF_REG_LIVE_BASE + 8'h08: rd_word = live.valu_start;
			`PROF_REG_LIVE_BASE + 8'h0c: rd_word = live.valu_finish;
			`PROF_REG_LIVE_BASE + 8'h10: rd_word = live.mem_start;
			`PROF_REG_LIVE_BASE + 8'h14: rd_word = live.mem_finish;
			`PROF_REG_SNAP_BASE + 8'h00: rd_word = snap.salu_start;
			`PROF_REG_SNAP_BASE + 8'h04: rd_word = snap.salu_finish;
			`PROF_REG_SNAP_BASE + 8'h08: rd_word = snap.valu_start;
			`PROF_REG_SNAP_BASE + 8'h0c: rd_word = snap.valu_finish;
			`PROF_REG_SNAP_BASE + 8'h10: rd_word = snap.mem_start;
			`PROF_REG_SNAP_BASE + 8'h14: rd_word = snap.mem_finish;
			default: begin
				rd_word = '0;
				rd_ok = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
		end else if (rd_hs) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	// read data is captured once and stays put while the host stalls
	always_ff @(posedge clk) begin
		if (rd_hs) begin
			rdata <= rd_word;
			rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

endmodule

// ==== src/prof_counter_bank.sv ====
module prof_counter_bank import prof_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  prof_events_t events,
	input  prof_ctrl_t   ctrl,
	output prof_counts_t live,
	output prof_counts_t snap,
	output prof_count_t  sample_seq
);

	prof_count_t timer;
	logic sampling;
	logic sample_end;

	// a zero period parks the timer and stops snapshots
	assign sampling = (ctrl.period != '0);

	// the compare also catches a timer left above a freshly shortened period
	assign sample_end = sampling && (timer >= ctrl.period - 1'b1);

	// live counters wrap at full width
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			live <= '0;
		end else if (ctrl.clear) begin
			live <= '0;
		end else if (ctrl.enable) begin
			live.salu_start <= live.salu_start + prof_count_t'(events.salu_start);
			live.salu_finish <= live.salu_finish + prof_count_t'(events.salu_finish);
			live.valu_start <= live.valu_start + prof_count_t'(events.valu_start);
			live.valu_finish <= live.valu_finish + prof_count_t'(events.valu_finish);
			live.mem_start <= live.mem_start + prof_count_t'(events.mem_start);
			live.mem_finish <= live.mem_finish + prof_count_t'(events.mem_finish);
		end
	end

	// the timer keeps running while counting is disabled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer <= '0;
		end else if (ctrl.clear || !sampling || sample_end) begin
			timer <= '0;
		end else begin
			timer <= timer + 1'b1;
		end
	end

	// snapshot takes the live values as they stand before this edge's update
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			snap <= '0;
			sample_seq <= '0;
		end else if (ctrl.clear) begin
			snap <= '0;
			sample_seq <= '0;
		end else if (sample_end) begin
			snap <= live;
			sample_seq <= sample_seq + 1'b1;
		end
	end

endmodule

// ==== src/prof_event_decode.sv ====
`include "prof_macros.svh"

module prof_event_decode import prof_pkg::*; (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         salu_done,
	input  logic         salu_branch_en,
	input  logic         salu_select,
	input  vec_mask_t    vec_done,
	input  vec_mask_t    vec_select,
	input  vec_mask_t    vec_fu_select,
	input  logic         lsu_select,
	input  logic         lsu_sgpr_done,
	input  logic         lsu_vgpr_done,
	output prof_events_t events
);

	vec_mask_t pair_q;
	vec_mask_t pair_d;
	vec_mask_t credit;
	prof_events_t events_d;

	function automatic vec_cnt_t count_ones(input vec_mask_t mask);
		vec_cnt_t n;
		n = '0;
		for (int i = 0; i < `PROF_NUM_VEC_UNITS; i++) begin
			n = n + vec_cnt_t'(mask[i]);
		end
		return n;
	endfunction

	// a done with the flag set is a finish
	// on any done the flag follows the register-select bit, so a done with select
	// high arms the unit and one with select low disarms it after crediting
	always_comb begin
		credit = pair_q & vec_done;
		pair_d = (vec_done & vec_fu_select) | (~vec_done & pair_q);
	end

	always_comb begin
		events_d.salu_start = salu_select;
		events_d.salu_finish = salu_done | salu_branch_en;
		events_d.valu_start = count_ones(vec_select);
		events_d.valu_finish = count_ones(credit);
		events_d.mem_start = lsu_select;
		events_d.mem_finish = lsu_sgpr_done | lsu_vgpr_done;
	end

	// flags start armed, every unit's first done counts
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pair_q <= '1;
		end else begin
			pair_q <= pair_d;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			events <= '0;
		end else begin
			events <= events_d;
		end
	end

endmodule

// ==== src/prof_pkg.sv ====
`include "prof_macros.svh"

package prof_pkg;

	typedef logic [`PROF_DATA_W-1:0] prof_count_t;
	typedef logic [`PROF_NUM_VEC_UNITS-1:0] vec_mask_t;
	typedef logic [`PROF_ADDR_W-1:0] reg_addr_t;
	typedef logic [`PROF_VEC_CNT_W-1:0] vec_cnt_t;

	// everything that happened in the compute unit during one cycle
	typedef struct packed {
		logic salu_start;
		logic salu_finish;
		vec_cnt_t valu_start;
		vec_cnt_t valu_finish;
		logic mem_start;
		logic mem_finish;
	} prof_events_t;

	// clear is a single cycle pulse
	typedef struct packed {
		logic enable;
		logic clear;
		prof_count_t period;
	} prof_ctrl_t;

	// field order matches the register map
	typedef struct packed {
		prof_count_t salu_start;
		prof_count_t salu_finish;
		prof_count_t valu_start;
		prof_count_t valu_finish;
		prof_count_t mem_start;
		prof_count_t mem_finish;
	} prof_counts_t;

endpackage

// ==== src/prof_macros.svh ====
`ifndef PROF_MACROS_SVH
`define PROF_MACROS_SVH

// four SIMD followed by four SIMF units
`define PROF_NUM_VEC_UNITS 8

// enough bits to count every vector unit in a single cycle
`define PROF_VEC_CNT_W 4

`define PROF_DATA_W 32
`define PROF_STRB_W (`PROF_DATA_W / 8)
`define PROF_ADDR_W 8

// snapshot interval in clock cycles after reset
`define PROF_DEFAULT_PERIOD 32'd100

// host register map, byte offsets
`define PROF_REG_CTRL 8'h00
`define PROF_REG_PERIOD 8'h04
`define PROF_REG_SEQ 8'h08

// six words each, salu start/finish, valu start/finish, mem start/finish
`define PROF_REG_LIVE_BASE 8'h10
`define PROF_REG_SNAP_BASE 8'h30

`endif
